//--- tb/dl11_stim.txt
# W/R addr(octal) data(hex) | P addr(octal) bit(dec) | N addr(octal)
# S/T char(hex) | I level(0/1) vector(hex), 30 is vector 060 and 34 is 064
R 17560 0000
R 17564 0080
I 0 00
N 17556
N 17570
N 17561
W 17560 0040
R 17560 0040
W 17564 0040
R 17564 00c0
I 1 34
W 17560 0000
W 17564 0000
I 0 00
W 17566 0041
R 17564 0000
T 41
P 17564 7
R 17564 0080
R 17566 0041
W 17566 00a5
T a5
P 17564 7
W 17566 00ff
R 17564 0000
W 17566 0012
T ff
P 17564 7
R 17566 00ff
S 5c
P 17560 7
R 17560 0080
R 17562 005c
R 17560 0000
W 17564 0040
I 1 34
W 17560 0040
S c3
P 17560 7
I 1 30
R 17562 00c3
I 1 34
W 17560 0000
W 17564 0000
I 0 00
S 7e
W 17566 0039
R 17564 0000
T 39
P 17560 7
R 17562 007e
R 17560 0000
P 17564 7
R 17564 0080

//--- dl11_console.f
+incdir+logic
logic/dl11_pkg.sv
logic/baud_gen.sv
logic/serial_tx.sv
logic/serial_rx.sv
logic/dl11_regs.sv
logic/dl11_console.sv
tb/dl11_console_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the DL11 console testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
   --top-module dl11_console_tb \
   -f dl11_console.f \
   --Mdir obj_dir -o dl11_sim

./obj_dir/dl11_sim | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
   echo "simulation failed, see $LOG"
   exit 1
fi

echo "simulation passed, log in $LOG"

//--- tb/dl11_console_tb.sv
// DL11 console testbench
// runs bus, serial and interrupt commands from a stim file against the console
// and decodes transmitted frames in the background

`timescale 1ns/1ps
`default_nettype none

`include "dl11_settings.svh"

module dl11_console_tb
   import dl11_pkg::*;
;

   localparam int BIT_CLKS   = `DL11_CLKS_PER_BIT;
   localparam int POLL_LIMIT = 24 * `DL11_CLKS_PER_BIT;

   logic         clk;
   logic         reset;
   iopage_addr_t iopage_addr;
   word_t        data_in;
   logic         iopage_rd;
   logic         iopage_wr;
   word_t        data_out;
   logic         decode;
   logic         interrupt;
   vector_t      vector;
   logic         rs232_tx;
   logic         rs232_rx;

   string        stim_lines[$];
   char_t        send_queue[$];
   char_t        tx_frames[$];
   int           value_errors;
   int           other_errors;
   int           frame_errors;
   int unsigned  timeout_cycles = 0;
   int unsigned  cycle_count = 0;

   dl11_console dut (
      .clk         (clk),
      .reset       (reset),
      .iopage_addr (iopage_addr),
      .data_in     (data_in),
      .iopage_rd   (iopage_rd),
      .iopage_wr   (iopage_wr),
      .data_out    (data_out),
      .decode      (decode),
      .interrupt   (interrupt),
      .vector      (vector),
      .rs232_tx    (rs232_tx),
      .rs232_rx    (rs232_rx)
   );

   always #20 clk = ~clk;

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_char(input string name, input char_t got, input char_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_vector(input string name, input vector_t got, input vector_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("FAIL %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic bus_write(input iopage_addr_t addr, input word_t data);
      @(negedge clk);
      iopage_addr = addr;
      data_in     = data;
      iopage_wr   = 1'b1;
      @(negedge clk);
      iopage_wr   = 1'b0;
   endtask

   // address settles for a cycle, then data is sampled and rd strobes
   task automatic bus_read(input iopage_addr_t addr, output word_t val, output logic dec);
      @(negedge clk);
      iopage_addr = addr;
      @(negedge clk);
      val       = data_out;
      dec       = decode;
      iopage_rd = 1'b1;
      @(negedge clk);
      iopage_rd = 1'b0;
   endtask

   task automatic poll_bit(input iopage_addr_t addr, input int bit_num);
      word_t val;
      logic  dec;
      int    waited;
      waited = 0;
      bus_read(addr, val, dec);
      while (val[bit_num] !== 1'b1 && waited < POLL_LIMIT)
      begin
         bus_read(addr, val, dec);
         waited = waited + 3;
      end
      if (val[bit_num] !== 1'b1)
      begin
         other_errors++;
         $display("ERROR: bit %0d of register %o never read 1 within %0d cycles",
                  bit_num, addr, POLL_LIMIT);
      end
   endtask

   task automatic send_frame(input char_t ch);
      rs232_rx = 1'b0;
      repeat (BIT_CLKS) @(negedge clk);
      for (int i = 0; i < 8; i++)
      begin
         rs232_rx = ch[i];
         repeat (BIT_CLKS) @(negedge clk);
      end
      rs232_rx = 1'b1;
      repeat (BIT_CLKS) @(negedge clk);
   endtask

   task automatic load_stim();
      int    fd;
      string line;
      fd = $fopen("tb/dl11_stim.txt", "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("ERROR: could not open the stimulus file tb/dl11_stim.txt");
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#" && line.getc(0) != " ")
               stim_lines.push_back(line);
         end
         $fclose(fd);
      end
   endtask

   task automatic run_command(input string line);
      byte         cmd;
      string       rest;
      logic [31:0] arg_a;
      logic [31:0] arg_b;
      int          n;
      int          fields;
      word_t       val;
      logic        dec;
      cmd    = line.getc(0);
      rest   = line.substr(1, line.len() - 1);
      n      = 0;
      fields = 0;
      case (cmd)
         "W":
         begin
            fields = 2;
            n = $sscanf(rest, "%o %h", arg_a, arg_b);
            bus_write(arg_a[12:0], arg_b[15:0]);
         end
         "R":
         begin
            fields = 2;
            n = $sscanf(rest, "%o %h", arg_a, arg_b);
            bus_read(arg_a[12:0], val, dec);
            check_bit($sformatf("decode @%o", arg_a[12:0]), dec, 1'b1);
            check_word($sformatf("data_out @%o", arg_a[12:0]), val, arg_b[15:0]);
         end
         "P":
         begin
            fields = 2;
            n = $sscanf(rest, "%o %d", arg_a, arg_b);
            poll_bit(arg_a[12:0], int'(arg_b));
         end
         "N":
         begin
            fields = 1;
            n = $sscanf(rest, "%o", arg_a);
            @(negedge clk);
            iopage_addr = arg_a[12:0];
            @(negedge clk);
            check_bit($sformatf("decode @%o", arg_a[12:0]), decode, 1'b0);
            check_word($sformatf("data_out @%o", arg_a[12:0]), data_out, '0);
         end
         "S":
         begin
            fields = 1;
            n = $sscanf(rest, "%h", arg_a);
            send_queue.push_back(arg_a[7:0]);
         end
         "T":
         begin
            fields = 1;
            n = $sscanf(rest, "%h", arg_a);
            while (tx_frames.size() == 0)
               @(negedge clk);
            check_char("rs232_tx frame", tx_frames.pop_front(), arg_a[7:0]);
         end
         "I":
         begin
            fields = 2;
            n = $sscanf(rest, "%d %h", arg_a, arg_b);
            @(negedge clk);
            check_bit("interrupt", interrupt, arg_a[0]);
            check_vector("vector", vector, arg_b[7:0]);
         end
         default:
         begin
            other_errors++;
            $display("ERROR: unknown stimulus command in line: %s", line);
         end
      endcase
      // a short line leaves its arguments unset
      if (n != fields)
      begin
         other_errors++;
         $display("ERROR: stimulus line has %0d of %0d fields: %s", n, fields, line);
      end
   endtask

   task automatic report_counts();
      $display("errors: %0d value mismatches, %0d poll or stim errors, %0d frame errors",
               value_errors, other_errors, frame_errors);
   endtask

   // serial line driver, frames queue up so the bus side keeps running
   initial
   begin
      char_t ch;
      rs232_rx = 1'b1;
      forever
      begin
         @(negedge clk);
         if (send_queue.size() > 0)
         begin
            ch = send_queue.pop_front();
            send_frame(ch);
         end
      end
   end

   // frame decoder on rs232_tx, samples mid-bit after the start edge
   initial
   begin
      char_t ch;
      frame_errors = 0;
      @(negedge reset);
      forever
      begin
         @(negedge rs232_tx);
         repeat (BIT_CLKS / 2) @(negedge clk);
         if (rs232_tx !== 1'b0)
         begin
            frame_errors++;
            $display("ERROR: start bit on rs232_tx did not stay low to mid-bit");
         end
         for (int i = 0; i < 8; i++)
         begin
            repeat (BIT_CLKS) @(negedge clk);
            ch[i] = rs232_tx;
         end
         repeat (BIT_CLKS) @(negedge clk);
         if (rs232_tx !== 1'b1)
         begin
            frame_errors++;
            $display("ERROR: stop bit on rs232_tx was not high for character 0x%h", ch);
         end
         tx_frames.push_back(ch);
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (timeout_cycles != 0 && cycle_count >= timeout_cycles)
      begin
         $display("ERROR: run did not finish within %0d cycles", timeout_cycles);
         report_counts();
         $display("Test failures found");
         $finish;
      end
   end

   initial
   begin
      int gap;
      void'($urandom(21685));
      clk          = 1'b0;
      reset        = 1'b1;
      iopage_addr  = '0;
      data_in      = '0;
      iopage_rd    = 1'b0;
      iopage_wr    = 1'b0;
      value_errors = 0;
      other_errors = 0;
      load_stim();
      timeout_cycles = stim_lines.size() * 12 * BIT_CLKS + 100;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      check_bit("rs232_tx", rs232_tx, 1'b1);
      foreach (stim_lines[i])
      begin
         gap = $urandom % 8;
         repeat (gap) @(negedge clk);
         run_command(stim_lines[i]);
      end
      report_counts();
      if (value_errors + other_errors + frame_errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/dl11_console.sv
// DL11 console serial line
// register block on the I/O page driving an 8N1 transmitter and receiver

`timescale 1ns/1ps
`default_nettype none

module dl11_console
   import dl11_pkg::*;
(
   input  wire          clk,
   input  wire          reset,
   input  iopage_addr_t iopage_addr,
   input  word_t        data_in,
   input  wire          iopage_rd,
   input  wire          iopage_wr,
   output word_t        data_out,
   output logic         decode,
   output logic         interrupt,
   output vector_t      vector,
   output logic         rs232_tx,
   input  wire          rs232_rx
);

   logic  rx_tick;
   logic  tx_tick;
   logic  tx_load;
   char_t tx_char;
   logic  tx_busy;
   logic  rx_full;
   char_t rx_char;
   logic  rx_unload;

   dl11_regs regs (
      .clk         (clk),
      .reset       (reset),
      .iopage_addr (iopage_addr),
      .data_in     (data_in),
      .iopage_rd   (iopage_rd),
      .iopage_wr   (iopage_wr),
      .data_out    (data_out),
      .decode      (decode),
      .interrupt   (interrupt),
      .vector      (vector),
      .tx_load     (tx_load),
      .tx_char     (tx_char),
      .tx_busy     (tx_busy),
      .rx_full     (rx_full),
      .rx_char     (rx_char),
      .rx_unload   (rx_unload)
   );

   baud_gen baud (
      .clk     (clk),
      .reset   (reset),
      .rx_tick (rx_tick),
      .tx_tick (tx_tick)
   );

   serial_tx xmit (
      .clk     (clk),
      .reset   (reset),
      .tx_tick (tx_tick),
      .tx_load (tx_load),
      .tx_char (tx_char),
      .tx_busy (tx_busy),
      .tx_out  (rs232_tx)
   );

   serial_rx recv (
      .clk       (clk),
      .reset     (reset),
      .rx_tick   (rx_tick),
      .rx_in     (rs232_rx),
      .rx_unload (rx_unload),
      .rx_full   (rx_full),
      .rx_char   (rx_char)
   );

endmodule

`default_nettype wire

//--- logic/dl11_regs.sv
// DL11 register block
// I/O page decode, RCSR/RBUF/XCSR/XBUF, transmit and receive handoff,
// interrupt request and vector selection

`timescale 1ns/1ps
`default_nettype none

`include "dl11_settings.svh"

module dl11_regs
   import dl11_pkg::*;
(
   input  wire          clk,
   input  wire          reset,
   input  iopage_addr_t iopage_addr,
   input  word_t        data_in,
   input  wire          iopage_rd,
   input  wire          iopage_wr,
   output word_t        data_out,
   output logic         decode,
   output logic         interrupt,
   output vector_t      vector,
   output logic         tx_load,
   output char_t        tx_char,
   input  wire          tx_busy,
   input  wire          rx_full,
   input  char_t        rx_char,
   output logic         rx_unload
);

   xmit_seq_t xmit_state;
   logic      ready;
   logic      done;
   logic      rx_ie;
   logic      tx_ie;
   char_t     xbuf;
   char_t     rbuf;
   logic      xbuf_wr;
   logic      rbuf_rd;
   logic      rx_req;
   logic      tx_req;

   assign decode = (iopage_addr == `DL11_RCSR_ADDR) ||
                   (iopage_addr == `DL11_RBUF_ADDR) ||
                   (iopage_addr == `DL11_XCSR_ADDR) ||
                   (iopage_addr == `DL11_XBUF_ADDR);

   // read mux, anything outside the four registers reads zero
   always_comb
   begin
      case (iopage_addr)
         `DL11_RCSR_ADDR: data_out = {8'b0, done, rx_ie, 6'b0};
         `DL11_RBUF_ADDR: data_out = {8'b0, rbuf};
         `DL11_XCSR_ADDR: data_out = {8'b0, ready, tx_ie, 6'b0};
         `DL11_XBUF_ADDR: data_out = {8'b0, xbuf};
         default:         data_out = '0;
      endcase
   end

   // writes to XBUF only count while the transmitter is ready
   assign xbuf_wr = iopage_wr && (iopage_addr == `DL11_XBUF_ADDR) && ready;
   assign rbuf_rd = iopage_rd && (iopage_addr == `DL11_RBUF_ADDR);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_ie <= 1'b0;
         tx_ie <= 1'b0;
      end
      else if (iopage_wr)
      begin
         if (iopage_addr == `DL11_RCSR_ADDR)
            rx_ie <= data_in[6];
         if (iopage_addr == `DL11_XCSR_ADDR)
            tx_ie <= data_in[6];
      end
   end

   always_ff @(posedge clk)
   begin
      if (xbuf_wr)
         xbuf <= data_in[7:0];
      if (rx_full)
         rbuf <= rx_char;
   end

   // hand the character to serial_tx, then follow busy through a full cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         xmit_state <= XMIT_READY;
      else
      begin
         case (xmit_state)
            XMIT_READY:
               if (xbuf_wr)
                  xmit_state <= XMIT_LOAD;
            XMIT_LOAD:
               xmit_state <= XMIT_WAIT_BUSY;
            XMIT_WAIT_BUSY:
               if (tx_busy)
                  xmit_state <= XMIT_WAIT_DONE;
            XMIT_WAIT_DONE:
               if (!tx_busy)
                  xmit_state <= XMIT_READY;
            default:
               xmit_state <= XMIT_READY;
         endcase
      end
   end

   assign ready   = (xmit_state == XMIT_READY);
   assign tx_load = (xmit_state == XMIT_LOAD);
   assign tx_char = xbuf;

   // receive side, a new character wins over a same-cycle RBUF read
   assign rx_unload = rx_full;

   always_ff @(posedge clk)
   begin
      if (reset)
         done <= 1'b0;
      else if (rx_full)
         done <= 1'b1;
      else if (rbuf_rd)
         done <= 1'b0;
   end

   // receiver has priority for the vector
   assign rx_req    = rx_ie && done;
   assign tx_req    = tx_ie && ready;
   assign interrupt = rx_req || tx_req;
   assign vector    = rx_req ? `DL11_RX_VECTOR :
                      tx_req ? `DL11_TX_VECTOR :
                      '0;

endmodule

`default_nettype wire

//--- logic/serial_rx.sv
// serial receiver
// samples rs232 input at 16x, frames 8N1 characters into a holding register

`timescale 1ns/1ps
`default_nettype none

module serial_rx
   import dl11_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   input  wire   rx_tick,
   input  wire   rx_in,
   input  wire   rx_unload,
   output logic  rx_full,
   output char_t rx_char
);

   rx_state_t  state;
   logic       rx_meta;
   logic       rx_sync;
   logic [3:0] tick_cnt;
   logic [2:0] bit_idx;
   char_t      shift_reg;

   // line is asynchronous, two flops before anything looks at it
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end
      else
      begin
         rx_meta <= rx_in;
         rx_sync <= rx_meta;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= RX_IDLE;
         tick_cnt <= '0;
         bit_idx  <= '0;
         rx_full  <= 1'b0;
      end
      else
      begin
         if (rx_unload)
            rx_full <= 1'b0;

         if (rx_tick)
         begin
            case (state)
               RX_IDLE:
                  if (!rx_sync)
                  begin
                     state    <= RX_START;
                     tick_cnt <= 4'd1;
                  end
               RX_START:
                  // 8th low sample is the middle of the start bit
                  if (tick_cnt == 4'd7)
                  begin
                     state    <= rx_sync ? RX_IDLE : RX_DATA;
                     tick_cnt <= '0;
                     bit_idx  <= '0;
                  end
                  else
                  begin
                     tick_cnt <= tick_cnt + 4'd1;
                  end
               RX_DATA:
               begin
                  tick_cnt <= tick_cnt + 4'd1;
                  if (tick_cnt == 4'd15)
                  begin
                     bit_idx <= bit_idx + 3'd1;
                     if (bit_idx == 3'd7)
                        state <= RX_STOP;
                  end
               end
               RX_STOP:
               begin
                  tick_cnt <= tick_cnt + 4'd1;
                  if (tick_cnt == 4'd15)
                  begin
                     state <= RX_IDLE;
                     // framing error drops the character
                     if (rx_sync)
                        rx_full <= 1'b1;
                  end
               end
               default:
                  state <= RX_IDLE;
            endcase
         end
      end
   end

   // lsb arrives first, shift in from the top
   always_ff @(posedge clk)
   begin
      if (rx_tick && state == RX_DATA && tick_cnt == 4'd15)
         shift_reg <= {rx_sync, shift_reg[7:1]};
      if (rx_tick && state == RX_STOP && tick_cnt == 4'd15 && rx_sync)
         rx_char <= shift_reg;
   end

endmodule

`default_nettype wire

//--- logic/serial_tx.sv
// serial transmitter
// shifts one character out as an 8N1 frame, one bit per tx_tick

`timescale 1ns/1ps
`default_nettype none

module serial_tx
   import dl11_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   input  wire   tx_tick,
   input  wire   tx_load,
   input  char_t tx_char,
   output logic  tx_busy,
   output logic  tx_out
);

   tx_state_t  state;
   char_t      shift_reg;
   logic [2:0] bit_idx;
   // character loaded, frame starts on the next bit tick
   logic       pending;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state   <= TX_IDLE;
         bit_idx <= '0;
         pending <= 1'b0;
      end
      else
      begin
         if (tx_load)
            pending <= 1'b1;

         case (state)
            TX_IDLE:
               if (pending && tx_tick)
               begin
                  state   <= TX_START;
                  pending <= 1'b0;
               end
            TX_START:
               if (tx_tick)
               begin
                  state   <= TX_DATA;
                  bit_idx <= '0;
               end
            TX_DATA:
               if (tx_tick)
               begin
                  if (bit_idx == 3'd7)
                     state <= TX_STOP;
                  bit_idx <= bit_idx + 3'd1;
               end
            TX_STOP:
               if (tx_tick)
                  state <= TX_IDLE;
            default:
               state <= TX_IDLE;
         endcase
      end
   end

   // data shifts right so bit 0 is always the one on the line
   always_ff @(posedge clk)
   begin
      if (tx_load)
         shift_reg <= tx_char;
      else if (state == TX_DATA && tx_tick)
         shift_reg <= {1'b0, shift_reg[7:1]};
   end

   assign tx_busy = (state != TX_IDLE);
   assign tx_out  = (state == TX_START) ? 1'b0 :
                    (state == TX_DATA)  ? shift_reg[0] :
                    1'b1;

endmodule

`default_nettype wire

//--- logic/baud_gen.sv
// baud generator
// 16x sampling tick for the receiver and a bit-rate tick for the transmitter

`timescale 1ns/1ps
`default_nettype none

`include "dl11_settings.svh"

module baud_gen
(
   input  wire  clk,
   input  wire  reset,
   output logic rx_tick,
   output logic tx_tick
);

   localparam int PRESCALE = `DL11_CLKS_PER_BIT / 16;
   localparam int PRE_W    = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

   logic [PRE_W-1:0] pre_cnt;
   logic [3:0]       tick_cnt;

   // one pulse per prescale period, every 16th of them is a bit tick
   assign rx_tick = (pre_cnt == PRE_W'(PRESCALE - 1));
   assign tx_tick = rx_tick && (tick_cnt == 4'd15);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         pre_cnt  <= '0;
         tick_cnt <= '0;
      end
      else if (rx_tick)
      begin
         pre_cnt  <= '0;
         tick_cnt <= tick_cnt + 4'd1;
      end
      else
      begin
         pre_cnt <= pre_cnt + PRE_W'(1);
      end
   end

endmodule

`default_nettype wire

//--- logic/dl11_pkg.sv
// DL11 console types
// bus, character and vector widths plus the state machine encodings

`default_nettype none

package dl11_pkg;

   typedef logic [12:0] iopage_addr_t;
   typedef logic [15:0] word_t;
   typedef logic [7:0]  char_t;
   typedef logic [7:0]  vector_t;

   // serial transmitter bit phases
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   // serial receiver bit phases
   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   // register side handoff to the transmitter
   typedef enum logic [1:0] {
      XMIT_READY,
      XMIT_LOAD,
      XMIT_WAIT_BUSY,
      XMIT_WAIT_DONE
   } xmit_seq_t;

endpackage

`default_nettype wire

//--- logic/dl11_settings.svh
// DL11 console settings
// I/O page register offsets, interrupt vectors and the serial bit timing

`ifndef DL11_SETTINGS_SVH
`define DL11_SETTINGS_SVH

// register offsets within the I/O page
`define DL11_RCSR_ADDR 13'o17560
`define DL11_RBUF_ADDR 13'o17562
`define DL11_XCSR_ADDR 13'o17564
`define DL11_XBUF_ADDR 13'o17566

// interrupt vectors, receiver and transmitter
`define DL11_RX_VECTOR 8'o060
`define DL11_TX_VECTOR 8'o064

// clk cycles per serial bit, keep it a multiple of 16
`define DL11_CLKS_PER_BIT 64

`endif
